/* Makefile */
# Verilator simulation of the FP slice

VERILATOR ?= verilator
TOP       ?= tb_fpslice
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= ALL CHECKS PASSED

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# Output goes to the terminal, pass or fail comes from the pass line
run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* hdl/fpslice_pkg.sv */
// FP slice shared definitions
package fpslice_pkg;

  // --------------------
  // Datapath geometry
  // --------------------
  localparam int unsigned WIDTH      = 32;
  localparam int unsigned NUM_LANES  = 2;
  localparam int unsigned FP32_WIDTH = 32;
  localparam int unsigned FP16_WIDTH = 16;

  // Canonical quiet NaNs
  localparam logic [31:0] FP32_QNAN = 32'h7fc00000;
  localparam logic [15:0] FP16_QNAN = 16'h7e00;

  // --------------------
  // Encodings
  // --------------------
  typedef enum logic {FP32 = 1'b0, FP16 = 1'b1} fp_format_e;

  typedef enum logic {SGNJ = 1'b0, MINMAX = 1'b1} operation_e;

  // Also picks the operation variant
  typedef enum logic [1:0] {RNE = 2'b00, RTZ = 2'b01, RDN = 2'b10, RUP = 2'b11} roundmode_e;

  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  typedef logic [7:0] tag_t;

  // Travels beside the result through the lane
  typedef struct packed {
    fp_format_e fmt;
    logic       vectorial;
  } aux_t;

  typedef struct packed {
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    fp_format_e       fmt;
    operation_e       op;
    roundmode_e       rnd;
    aux_t             aux;
    tag_t             tag;
  } lane_req_t;

  typedef struct packed {
    logic [WIDTH-1:0] result;
    status_t          status;
    aux_t             aux;
    tag_t             tag;
  } lane_rsp_t;

endpackage

/* hdl/fpslice_top.sv */
// FP operation slice top level
`timescale 1ns/1ps

module fpslice_top #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic [1:0][fpslice_pkg::WIDTH-1:0] operands_i,
  input  fpslice_pkg::roundmode_e            rnd_mode_i,
  input  fpslice_pkg::operation_e            op_i,
  input  fpslice_pkg::fp_format_e            fmt_i,
  input  logic                               vectorial_op_i,
  input  fpslice_pkg::tag_t                  tag_i,
  input  logic                               in_valid_i,
  output logic                               in_ready_o,
  input  logic                               flush_i,
  output logic [fpslice_pkg::WIDTH-1:0]      result_o,
  output fpslice_pkg::status_t               status_o,
  output fpslice_pkg::tag_t                  tag_o,
  output logic                               out_valid_o,
  input  logic                               out_ready_i,
  output logic                               busy_o
);
  import fpslice_pkg::*;

  lane_req_t [NUM_LANES-1:0] lane_req;
  lane_rsp_t [NUM_LANES-1:0] lane_rsp;
  logic      [NUM_LANES-1:0] lane_req_valid;
  logic      [NUM_LANES-1:0] lane_in_ready;
  logic      [NUM_LANES-1:0] lane_out_valid;
  logic      [NUM_LANES-1:0] lane_out_ready;
  logic      [NUM_LANES-1:0] lane_busy;

  lane_operand_split i_split (
    .operands_i     (operands_i),
    .fmt_i          (fmt_i),
    .op_i           (op_i),
    .rnd_mode_i     (rnd_mode_i),
    .vectorial_op_i (vectorial_op_i),
    .tag_i          (tag_i),
    .in_valid_i     (in_valid_i),
    .lane_req_o     (lane_req),
    .lane_valid_o   (lane_req_valid)
  );

  for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lane
    // Upper lanes accept only together with lane 0
    lane_sgnj_minmax #(
      .NumPipeRegs (NumPipeRegs)
    ) i_lane (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .flush_i     (flush_i),
      .req_i       (lane_req[l]),
      .in_valid_i  (lane_req_valid[l] & ((l == 0) | lane_in_ready[0])),
      .in_ready_o  (lane_in_ready[l]),
      .rsp_o       (lane_rsp[l]),
      .out_valid_o (lane_out_valid[l]),
      .out_ready_i (lane_out_ready[l]),
      .busy_o      (lane_busy[l])
    );
  end

  result_assembler i_assembler (
    .lane_rsp_i   (lane_rsp),
    .lane_valid_i (lane_out_valid),
    .out_ready_i  (out_ready_i),
    .lane_ready_o (lane_out_ready),
    .result_o     (result_o),
    .status_o     (status_o),
    .tag_o        (tag_o),
    .out_valid_o  (out_valid_o)
  );

  assign in_ready_o = lane_in_ready[0];
  assign busy_o     = |lane_busy;

endmodule

/* hdl/lane_operand_split.sv */
// Per-lane operand split
`timescale 1ns/1ps

module lane_operand_split (
  input  logic [1:0][fpslice_pkg::WIDTH-1:0]             operands_i,
  input  fpslice_pkg::fp_format_e                        fmt_i,
  input  fpslice_pkg::operation_e                        op_i,
  input  fpslice_pkg::roundmode_e                        rnd_mode_i,
  input  logic                                           vectorial_op_i,
  input  fpslice_pkg::tag_t                              tag_i,
  input  logic                                           in_valid_i,
  output fpslice_pkg::lane_req_t [fpslice_pkg::NUM_LANES-1:0] lane_req_o,
  output logic [fpslice_pkg::NUM_LANES-1:0]              lane_valid_o
);
  import fpslice_pkg::*;

  logic        vec_eff;
  int unsigned fmt_width;
  aux_t        aux;

  // FP32 fills the whole word, so only FP16 can be vectorial
  assign vec_eff   = vectorial_op_i & (fmt_i == FP16);
  assign fmt_width = (fmt_i == FP16) ? FP16_WIDTH : FP32_WIDTH;

  assign aux.fmt       = fmt_i;
  assign aux.vectorial = vec_eff;

  always_comb begin
    for (int unsigned l = 0; l < NUM_LANES; l++) begin
      // Upper bits past the format are ignored by the lane
      lane_req_o[l].a   = operands_i[0] >> (l * fmt_width);
      lane_req_o[l].b   = operands_i[1] >> (l * fmt_width);
      lane_req_o[l].fmt = fmt_i;
      lane_req_o[l].op  = op_i;
      lane_req_o[l].rnd = rnd_mode_i;
      lane_req_o[l].aux = aux;
      lane_req_o[l].tag = tag_i;

      // Upper lanes only run for vector operations
      lane_valid_o[l] = in_valid_i & ((l == 0) | vec_eff);
    end
  end

endmodule

/* hdl/lane_sgnj_minmax.sv */
// Sign injection and min/max lane
`timescale 1ns/1ps

module lane_sgnj_minmax #(
  parameter int unsigned NumPipeRegs = 0
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   flush_i,
  input  fpslice_pkg::lane_req_t req_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output fpslice_pkg::lane_rsp_t rsp_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic                   busy_o
);
  import fpslice_pkg::*;

  typedef struct packed {
    logic             sign;
    logic [WIDTH-2:0] mag;
    logic             nan;
    logic             snan;
    logic [WIDTH-1:0] val;
  } fp_info_t;

  // FP16 values sit in the low half and come out zero-extended
  function automatic fp_info_t decode_fp(logic [WIDTH-1:0] x, logic fp16);
    fp_info_t info;
    if (fp16) begin
      info.sign = x[15];
      info.mag  = {16'h0, x[14:0]};
      info.nan  = (&x[14:10]) & (|x[9:0]);
      info.snan = info.nan & ~x[9];
      info.val  = {16'h0, x[15:0]};
    end else begin
      info.sign = x[31];
      info.mag  = x[30:0];
      info.nan  = (&x[30:23]) & (|x[22:0]);
      info.snan = info.nan & ~x[22];
      info.val  = x;
    end
    return info;
  endfunction

  logic             is_fp16;
  fp_info_t         op_a;
  fp_info_t         op_b;
  logic             a_lt_b;
  logic             sgnj_sign;
  logic [WIDTH-1:0] sgnj_res;
  logic [WIDTH-1:0] minmax_res;
  lane_rsp_t        op_rsp;

  assign is_fp16 = (req_i.fmt == FP16);
  assign op_a    = decode_fp(req_i.a, is_fp16);
  assign op_b    = decode_fp(req_i.b, is_fp16);

  // --------------------
  // Operation logic
  // --------------------
  // Ordered compare on sign-magnitude, -0 sorts below +0
  always_comb begin
    if (op_a.sign != op_b.sign) begin
      a_lt_b = op_a.sign;
    end else if (op_a.sign) begin
      a_lt_b = (op_a.mag > op_b.mag);
    end else begin
      a_lt_b = (op_a.mag < op_b.mag);
    end
  end

  always_comb begin
    case (req_i.rnd)
      RTZ:     sgnj_sign = ~op_b.sign;
      RDN:     sgnj_sign = op_a.sign ^ op_b.sign;
      default: sgnj_sign = op_b.sign;
    endcase
    sgnj_res = is_fp16 ? {16'h0, sgnj_sign, op_a.mag[14:0]} : {sgnj_sign, op_a.mag};
  end

  // RTZ is max, other modes are min
  always_comb begin
    if (op_a.nan && op_b.nan) begin
      minmax_res = is_fp16 ? {16'h0, FP16_QNAN} : FP32_QNAN;
    end else if (op_a.nan) begin
      minmax_res = op_b.val;
    end else if (op_b.nan) begin
      minmax_res = op_a.val;
    end else if ((req_i.rnd == RTZ) ? ~a_lt_b : a_lt_b) begin
      minmax_res = op_a.val;
    end else begin
      minmax_res = op_b.val;
    end
  end

  always_comb begin
    op_rsp        = '0;
    op_rsp.aux    = req_i.aux;
    op_rsp.tag    = req_i.tag;
    if (req_i.op == SGNJ) begin
      op_rsp.result = sgnj_res;
    end else begin
      op_rsp.result    = minmax_res;
      op_rsp.status.nv = op_a.snan | op_b.snan;
    end
  end

  slice_pipe #(
    .NumPipeRegs (NumPipeRegs)
  ) i_pipe (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .data_i  (op_rsp),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_o  (rsp_o),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .busy_o  (busy_o)
  );

endmodule

/* hdl/result_assembler.sv */
// Lane result assembly
`timescale 1ns/1ps

module result_assembler (
  input  fpslice_pkg::lane_rsp_t [fpslice_pkg::NUM_LANES-1:0] lane_rsp_i,
  input  logic [fpslice_pkg::NUM_LANES-1:0]              lane_valid_i,
  input  logic                                           out_ready_i,
  output logic [fpslice_pkg::NUM_LANES-1:0]              lane_ready_o,
  output logic [fpslice_pkg::WIDTH-1:0]                  result_o,
  output fpslice_pkg::status_t                           status_o,
  output fpslice_pkg::tag_t                              tag_o,
  output logic                                           out_valid_o
);
  import fpslice_pkg::*;

  aux_t                 res_aux;
  logic [NUM_LANES-1:0] lane_used;

  // Lane 0 describes the result leaving the slice
  assign res_aux = lane_rsp_i[0].aux;

  // --------------------
  // Handshake
  // --------------------
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      lane_ready_o[l] = out_ready_i & ((l == 0) | res_aux.vectorial);
      lane_used[l]    = lane_valid_i[l] & ((l == 0) | res_aux.vectorial);
    end
  end

  assign out_valid_o = lane_valid_i[0];
  assign tag_o       = lane_rsp_i[0].tag;

  // --------------------
  // Packing
  // --------------------
  always_comb begin
    if (res_aux.fmt == FP32) begin
      result_o = lane_rsp_i[0].result;
    end else if (res_aux.vectorial) begin
      result_o = {lane_rsp_i[1].result[FP16_WIDTH-1:0], lane_rsp_i[0].result[FP16_WIDTH-1:0]};
    end else begin
      // NaN-box the unused upper half
      result_o = {16'hffff, lane_rsp_i[0].result[FP16_WIDTH-1:0]};
    end
  end

  // Status flags of all active lanes
  always_comb begin
    status_o = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (lane_used[l]) begin
        status_o = status_o | lane_rsp_i[l].status;
      end
    end
  end

endmodule

/* hdl/slice_pipe.sv */
// Valid/ready register pipeline
`timescale 1ns/1ps

module slice_pipe #(
  parameter int unsigned NumPipeRegs = 0
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   flush_i,
  input  fpslice_pkg::lane_rsp_t data_i,
  input  logic                   valid_i,
  output logic                   ready_o,
  output fpslice_pkg::lane_rsp_t data_o,
  output logic                   valid_o,
  input  logic                   ready_i,
  output logic                   busy_o
);

  // Index i is the view after i register stages
  fpslice_pkg::lane_rsp_t data_q  [0:NumPipeRegs];
  logic                   valid_q [0:NumPipeRegs];
  logic                   ready   [0:NumPipeRegs];

  assign data_q[0]  = data_i;
  assign valid_q[0] = valid_i;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic load;

    // Advance when the next stage moves on or holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    assign load     = ready[i] & valid_q[i];

    always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (load) begin
        data_q[i+1] <= data_q[i];
      end
    end
  end

  assign ready[NumPipeRegs] = ready_i;

  assign ready_o = ready[0];
  assign data_o  = data_q[NumPipeRegs];
  assign valid_o = valid_q[NumPipeRegs];

  // Any registered stage holding an item
  always_comb begin
    busy_o = 1'b0;
    for (int i = 1; i <= NumPipeRegs; i++) begin
      busy_o = busy_o | valid_q[i];
    end
  end

endmodule

/* list.f */
hdl/fpslice_pkg.sv
hdl/slice_pipe.sv
hdl/lane_sgnj_minmax.sv
hdl/lane_operand_split.sv
hdl/result_assembler.sv
hdl/fpslice_top.sv
verification/tb_clock_gen.sv
verification/tb_fpslice.sv

/* verification/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Synchronous reset, released on a rising edge
  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

/* verification/tb_fpslice.sv */
// FP slice testbench
`timescale 1ns/1ps

module tb_fpslice;
  import fpslice_pkg::*;

  localparam int unsigned NumPipeRegs = 2;
  localparam int unsigned PeriodNs    = 40;
  // Operations issued by all tests together
  localparam int unsigned TotalOps    = 16 + 27 + 8 + 8 + 2 + 1;
  localparam longint unsigned TimeoutNs = (TotalOps * (NumPipeRegs + 20) + 100) * PeriodNs;

  // qNaN, sNaN, negative sNaN, +0, -0, 1.0, -1.0, +inf
  localparam logic [7:0][15:0] Fp16Specials = {
    16'h7e00, 16'h7c01, 16'hfd00, 16'h0000, 16'h8000, 16'h3c00, 16'hbc00, 16'h7c00
  };

  typedef struct packed {
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    fp_format_e       fmt;
    operation_e       op;
    roundmode_e       rnd;
    logic             vec;
  } op_t;

  typedef struct packed {
    logic [WIDTH-1:0] result;
    status_t          status;
    tag_t             tag;
  } exp_t;

  logic                  clk;
  logic                  rst;
  logic [1:0][WIDTH-1:0] operands;
  roundmode_e            rnd_mode;
  operation_e            op;
  fp_format_e            fmt;
  logic                  vectorial_op;
  tag_t                  tag;
  logic                  in_valid;
  logic                  in_ready;
  logic                  flush;
  logic [WIDTH-1:0]      result;
  status_t               status;
  tag_t                  tag_out;
  logic                  out_valid;
  logic                  out_ready;
  logic                  busy;

  exp_t        exp_q[$];
  logic [31:0] rng_state;
  tag_t        next_tag;
  int          err_count;
  int          rx_count;
  int          test_count;
  int          test_fail;

  tb_clock_gen #(
    .PeriodNs    (PeriodNs),
    .ResetCycles (5)
  ) i_clock (
    .clk_o (clk),
    .rst_o (rst)
  );

  fpslice_top #(
    .NumPipeRegs (NumPipeRegs)
  ) dut (
    .clk_i          (clk),
    .rst_i          (rst),
    .operands_i     (operands),
    .rnd_mode_i     (rnd_mode),
    .op_i           (op),
    .fmt_i          (fmt),
    .vectorial_op_i (vectorial_op),
    .tag_i          (tag),
    .in_valid_i     (in_valid),
    .in_ready_o     (in_ready),
    .flush_i        (flush),
    .result_o       (result),
    .status_o       (status),
    .tag_o          (tag_out),
    .out_valid_o    (out_valid),
    .out_ready_i    (out_ready),
    .busy_o         (busy)
  );

  // --------------------
  // Reference model
  // --------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // One lane on a 16 or 32 bit value, returns {nv, result}
  function automatic logic [32:0] lane_ref(logic [31:0] a_in, logic [31:0] b_in, logic half,
                                           operation_e kind, roundmode_e rnd);
    logic [31:0] fm;
    logic [31:0] sm;
    logic [31:0] em;
    logic [31:0] mm;
    logic [31:0] qm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ka;
    logic [31:0] kb;
    logic [31:0] res;
    logic        a_nan;
    logic        b_nan;
    logic        nv;
    logic        sign;
    fm    = half ? 32'h0000_ffff : 32'hffff_ffff;
    sm    = half ? 32'h0000_8000 : 32'h8000_0000;
    em    = half ? 32'h0000_7c00 : 32'h7f80_0000;
    mm    = half ? 32'h0000_03ff : 32'h007f_ffff;
    qm    = half ? 32'h0000_0200 : 32'h0040_0000;
    a     = a_in & fm;
    b     = b_in & fm;
    a_nan = ((a & em) == em) && ((a & mm) != 0);
    b_nan = ((b & em) == em) && ((b & mm) != 0);
    nv    = 1'b0;
    if (kind == SGNJ) begin
      case (rnd)
        RTZ:     sign = (b & sm) == 0;
        RDN:     sign = ((a ^ b) & sm) != 0;
        default: sign = (b & sm) != 0;
      endcase
      res = (a & ~sm) | (sign ? sm : 32'h0);
    end else begin
      nv = (a_nan && (a & qm) == 0) || (b_nan && (b & qm) == 0);
      // Unsigned keys that sort in IEEE order, -0 below +0
      ka = ((a & sm) != 0) ? (~a & fm) : (a | sm);
      kb = ((b & sm) != 0) ? (~b & fm) : (b | sm);
      if (a_nan && b_nan) begin
        res = half ? 32'h0000_7e00 : 32'h7fc0_0000;
      end else if (a_nan) begin
        res = b;
      end else if (b_nan) begin
        res = a;
      end else if (rnd == RTZ) begin
        res = (ka >= kb) ? a : b;
      end else begin
        res = (ka <= kb) ? a : b;
      end
    end
    return {nv, res};
  endfunction

  function automatic exp_t model_op(op_t t, tag_t tg);
    logic [32:0] lo;
    logic [32:0] hi;
    exp_t        e;
    e     = '0;
    e.tag = tg;
    if (t.fmt == FP32) begin
      lo          = lane_ref(t.a, t.b, 1'b0, t.op, t.rnd);
      e.result    = lo[31:0];
      e.status.nv = lo[32];
    end else begin
      lo = lane_ref(t.a, t.b, 1'b1, t.op, t.rnd);
      hi = lane_ref(t.a >> 16, t.b >> 16, 1'b1, t.op, t.rnd);
      if (t.vec) begin
        e.result    = {hi[15:0], lo[15:0]};
        e.status.nv = lo[32] | hi[32];
      end else begin
        e.result    = {16'hffff, lo[15:0]};
        e.status.nv = lo[32];
      end
    end
    return e;
  endfunction

  function automatic logic [15:0] pick_half();
    logic [31:0] r;
    r = next_rand();
    return r[3] ? Fp16Specials[r[2:0]] : r[31:16];
  endfunction

  function automatic op_t random_op(fp_format_e fmt_sel, logic vec);
    logic [31:0] r;
    op_t         t;
    r     = next_rand();
    t.a   = next_rand();
    t.b   = next_rand();
    t.fmt = fmt_sel;
    t.op  = operation_e'(r[0]);
    t.rnd = roundmode_e'(r[2:1]);
    t.vec = vec;
    return t;
  endfunction

  function automatic op_t vec_minmax_op(logic [31:0] a, logic [31:0] b, roundmode_e rnd);
    op_t t;
    t.a   = a;
    t.b   = b;
    t.fmt = FP16;
    t.op  = MINMAX;
    t.rnd = rnd;
    t.vec = 1'b1;
    return t;
  endfunction

  // --------------------
  // Driving and checking
  // --------------------
  // Called on a rising edge, leaves the request asserted
  task automatic drive_request(input op_t t);
    operands     <= {t.b, t.a};
    fmt          <= t.fmt;
    op           <= t.op;
    rnd_mode     <= t.rnd;
    vectorial_op <= t.vec;
    tag          <= next_tag;
    in_valid     <= 1'b1;
    exp_q.push_back(model_op(t, next_tag));
    next_tag = next_tag + 8'd1;
  endtask

  // Returns on the rising edge that accepted the request
  task automatic issue(input op_t t);
    drive_request(t);
    do begin
      @(negedge clk);
    end while (!in_ready);
    @(posedge clk);
  endtask

  task automatic go_idle();
    in_valid <= 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || busy) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, err_count - errs_before);
      test_fail++;
    end
  endtask

  // Results leave on the next rising edge when valid and ready are both high
  always @(negedge clk) begin : monitor
    exp_t e;
    if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("Error: a result came out with no request pending, tag %h", tag_out);
        err_count++;
      end else begin
        e = exp_q.pop_front();
        rx_count++;
        if (result !== e.result) begin
          $display("Fail result_o expected %h got %h (tag %h)", e.result, result, e.tag);
          err_count++;
        end
        if (status !== e.status) begin
          $display("Fail status_o expected %h got %h (tag %h)", e.status, status, e.tag);
          err_count++;
        end
        if (tag_out !== e.tag) begin
          $display("Fail tag_o expected %h got %h", e.tag, tag_out);
          err_count++;
        end
      end
    end
  end

  // --------------------
  // Tests
  // --------------------
  task automatic reset_state_test();
    int errs;
    errs = err_count;
    @(negedge clk);
    if (out_valid !== 1'b0) begin
      $display("Fail out_valid_o expected %h got %h", 1'b0, out_valid);
      err_count++;
    end
    if (busy !== 1'b0) begin
      $display("Fail busy_o expected %h got %h", 1'b0, busy);
      err_count++;
    end
    if (in_ready !== 1'b1) begin
      $display("Fail in_ready_o expected %h got %h", 1'b1, in_ready);
      err_count++;
    end
    @(posedge clk);
    report_test("reset state", errs);
  endtask

  task automatic scalar_fp32_sgnj();
    int          errs;
    op_t         t;
    logic [31:0] r;
    errs = err_count;
    for (int i = 0; i < 16; i++) begin
      r     = next_rand();
      // FP32 stays scalar whatever the vectorial input says
      t     = random_op(FP32, r[5]);
      t.op  = SGNJ;
      t.rnd = roundmode_e'(i[1:0]);
      issue(t);
    end
    go_idle();
    drain();
    report_test("scalar FP32 SGNJ", errs);
  endtask

  task automatic vector_fp16_minmax();
    int  errs;
    op_t t;
    errs = err_count;
    // Both-NaN upper half, signed zeros in the lower half
    issue(vec_minmax_op({16'h7e00, 16'h0000}, {16'h7c01, 16'h8000}, RNE));
    issue(vec_minmax_op({16'h7e00, 16'h8000}, {16'h7e00, 16'h0000}, RTZ));
    issue(vec_minmax_op({16'h7c01, 16'h3c00}, {16'h3c00, 16'h7e00}, RUP));
    for (int i = 0; i < 24; i++) begin
      t      = random_op(FP16, 1'b1);
      t.op   = MINMAX;
      t.a    = {pick_half(), pick_half()};
      t.b    = {pick_half(), pick_half()};
      issue(t);
    end
    go_idle();
    drain();
    report_test("vector FP16 MINMAX", errs);
  endtask

  task automatic scalar_fp16_boxing();
    int  errs;
    op_t t;
    errs = err_count;
    for (int i = 0; i < 8; i++) begin
      t         = random_op(FP16, 1'b0);
      t.op      = operation_e'(i[0]);
      t.a[15:0] = pick_half();
      issue(t);
    end
    go_idle();
    drain();
    report_test("scalar FP16 NaN-boxing", errs);
  endtask

  task automatic backpressure_and_flush();
    int   errs;
    int   rx_before;
    int   sent;
    logic fell;
    errs      = err_count;
    rx_before = rx_count;
    sent      = 0;
    fell      = 1'b0;
    out_ready <= 1'b0;
    for (int i = 0; i < 8 && !fell; i++) begin
      drive_request(random_op(FP32, 1'b0));
      sent++;
      @(negedge clk);
      if (!in_ready) begin
        fell = 1'b1;
      end
      @(posedge clk);
    end
    out_ready <= 1'b1;
    if (fell) begin
      // The stalled request goes in once the output drains
      do begin
        @(negedge clk);
      end while (!in_ready);
      @(posedge clk);
    end else begin
      $display("Error: in_ready_o never fell while out_ready_i was held low");
      err_count++;
    end
    go_idle();
    drain();
    if (rx_count - rx_before != sent) begin
      $display("Error: %0d requests sent but %0d results came back", sent, rx_count - rx_before);
      err_count++;
    end

    // Two items in flight, then flushed
    out_ready <= 1'b0;
    issue(random_op(FP16, 1'b1));
    issue(random_op(FP32, 1'b0));
    go_idle();
    flush <= 1'b1;
    exp_q.delete();
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    if (out_valid !== 1'b0) begin
      $display("Fail out_valid_o expected %h got %h", 1'b0, out_valid);
      err_count++;
    end
    if (busy !== 1'b0) begin
      $display("Fail busy_o expected %h got %h", 1'b0, busy);
      err_count++;
    end
    @(posedge clk);
    out_ready <= 1'b1;
    issue(random_op(FP16, 1'b1));
    go_idle();
    drain();
    report_test("back-pressure and flush", errs);
  endtask

  // --------------------
  // Run control
  // --------------------
  initial begin
    #(TimeoutNs);
    $display("Error: the run timed out after %0d ns", TimeoutNs);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    operands     = '0;
    rnd_mode     = RNE;
    op           = SGNJ;
    fmt          = FP32;
    vectorial_op = 1'b0;
    tag          = '0;
    in_valid     = 1'b0;
    flush        = 1'b0;
    out_ready    = 1'b1;
    rng_state    = 32'h5d65_3d14;
    next_tag     = '0;
    err_count    = 0;
    rx_count     = 0;
    test_count   = 0;
    test_fail    = 0;

    @(negedge rst);
    @(posedge clk);

    reset_state_test();
    scalar_fp32_sgnj();
    vector_fp16_minmax();
    scalar_fp16_boxing();
    backpressure_and_flush();

    $display("Summary: %0d tests, %0d failed, %0d errors, %0d results checked",
             test_count, test_fail, err_count, rx_count);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
